/* tb.f */
source/grid_pkg.sv
source/vga_sync.sv
source/pointer_mover.sv
source/grid_engine.sv
source/pixel_renderer.sv
source/grid_display_top.sv
sim/grid_display_chk.sv
sim/grid_display_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the grid display testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module grid_display_tb -o grid_display_sim > build.log 2>&1; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/grid_display_sim > sim.log 2>&1
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status, see sim.log"
	exit 1
fi

if grep -qx "Regression passed" sim.log; then
	echo "PASS"
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1

/* sim/grid_display_tb.sv */
`timescale 1ns/1ps

module grid_display_tb import grid_pkg::*; ();

	logic        clk_in = 1'b0;
	logic        rst;
	logic        cmd_valid;
	logic        cmd_ready;
	cmd_op_t     cmd_op;
	rgb_t        rgb;
	logic        hsync;
	logic        vsync;
	cell_pos_t   pointer_pos;
	cell_state_t pointer_state;

	cell_state_t model [grid_w][grid_h]; // Expected cell states
	cell_pos_t   mptr;                   // Expected pointer

	logic [31:0] lfsr_q      = 32'h4529_033d;
	int          frame_clk   = 2 * h_total * v_total; // Two clocks per pixel
	int          line_clk    = 2 * h_total;
	int          cyc         = 0;    // Clocks since reset release
	int          tcount      = 0;    // Clocks since time zero
	int          frame_start = 0;
	logic        frame_on    = 1'b0;
	logic        pend_pos    = 1'b0; // Move seen, pointer due
	logic        pend_state  = 1'b0; // Action seen, state due
	logic        hs_d        = 1'b1;
	logic        vs_d        = 1'b1;
	int          hs_last     = 0;
	int          vs_fall     = 0;
	int          hs_meas     = 0;
	int          vs_meas     = 0;
	int          vsw_meas    = 0;
	int          stall;
	int          v;

	grid_display_top UUT (
		.clk_in        (clk_in),
		.rst           (rst),
		.cmd_valid     (cmd_valid),
		.cmd_ready     (cmd_ready),
		.cmd_op        (cmd_op),
		.rgb           (rgb),
		.hsync         (hsync),
		.vsync         (vsync),
		.pointer_pos   (pointer_pos),
		.pointer_state (pointer_state)
	);

	always #10 clk_in = ~clk_in; // 20 ns period

	// Taps 32,22,2,1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q); // One step per bit
			val    = (val << 1) | int'(lfsr_q[0]);
		end
	endtask

	// Marking rules and clamped pointer moves
	task automatic model_apply(input cmd_op_t op);
		case (op)
			op_up:    if (mptr.y != 4'd0) mptr.y = mptr.y - 4'd1;
			op_down:  if (mptr.y != 4'(grid_h - 1)) mptr.y = mptr.y + 4'd1;
			op_left:  if (mptr.x != 4'd0) mptr.x = mptr.x - 4'd1;
			op_right: if (mptr.x != 4'(grid_w - 1)) mptr.x = mptr.x + 4'd1;
			op_reveal: if (model[mptr.x][mptr.y] == cell_hidden)
				model[mptr.x][mptr.y] = cell_revealed;
			op_flag: begin
				if (model[mptr.x][mptr.y] == cell_hidden)
					model[mptr.x][mptr.y] = cell_flagged;
				else if (model[mptr.x][mptr.y] == cell_flagged)
					model[mptr.x][mptr.y] = cell_hidden; // Revealed stays put
			end
			default: ;
		endcase
	endtask

	// Expected colour of pixel h,v
	function automatic rgb_t ref_colour(int h, int vv);
		int cx;
		int cy;
		int rx;
		int ry;
		if (h >= h_active || vv >= v_active)
			return col_black; // Blanking
		cx = h / cell_px;
		cy = vv / cell_px;
		rx = h % cell_px;
		ry = vv % cell_px;
		if (cx == int'(mptr.x) && cy == int'(mptr.y) &&
			(rx == 0 || rx == cell_px - 1 || ry == 0 || ry == cell_px - 1))
			return col_pointer;
		case (model[cx][cy])
			cell_revealed: return col_revealed;
			cell_flagged:  return col_flagged;
			default:       return col_hidden;
		endcase
	endfunction

	task automatic report_fail();
		$display("Regression failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_state(cell_state_t got, cell_state_t exp, string what);
		if (got !== exp) begin
			$display("Fail at time %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
			report_fail();
		end
	endtask

	task automatic check_pos(cell_pos_t got, cell_pos_t exp, string what);
		if (got !== exp) begin
			$display("Fail at time %0t: %s is %0d,%0d, expected %0d,%0d", $time, what,
				got.x, got.y, exp.x, exp.y);
			report_fail();
		end
	endtask

	task automatic check_rgb(rgb_t got, rgb_t exp, string what);
		if (got !== exp) begin
			$display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
			report_fail();
		end
	endtask

	task automatic check_cycles(int got, int exp, string what);
		if (got != exp) begin
			$display("Fail at time %0t: %s is %0d clocks, expected %0d", $time, what, got, exp);
			report_fail();
		end
	endtask

	// Called on a rising edge, returns on one
	task automatic send_cmd(input cmd_op_t op);
		int gap;
		cmd_valid <= 1'b1;
		cmd_op    <= op;
		@(posedge clk_in);
		while (!cmd_ready)
			@(posedge clk_in);
		cmd_valid <= 1'b0;
		take_bits(2, gap); // Idle clocks, 0..3
		repeat (gap) @(posedge clk_in);
	endtask

	task automatic mark_sequence();
		send_cmd(op_flag);
		send_cmd(op_flag);
		send_cmd(op_flag);
		send_cmd(op_reveal); // Flagged cell ignores it
		send_cmd(op_flag);
		send_cmd(op_reveal);
		send_cmd(op_flag);   // Revealed cell ignores it
	endtask

	always @(posedge clk_in) begin
		cyc    <= rst ? 0 : cyc + 1;
		tcount <= tcount + 1;
		if (tcount > 3 * frame_clk + cell_count + 20000) begin
			$display("Timeout: the run did not finish within the cycle limit");
			report_fail();
		end
	end

	// Transfer monitor, updates the model
	always @(posedge clk_in) begin
		pend_pos   <= 1'b0;
		pend_state <= 1'b0;
		if (!rst && cmd_valid && cmd_ready) begin
			model_apply(cmd_op);
			if (cmd_op == op_reveal || cmd_op == op_flag)
				pend_state <= 1'b1;
			else
				pend_pos <= 1'b1;
		end
	end

	// Compare one clock after the transfer
	always @(negedge clk_in) begin
		if (pend_pos)
			check_pos(pointer_pos, mptr, "pointer after move");
		if (pend_state)
			check_state(pointer_state, model[mptr.x][mptr.y], "state after action");
	end

	// Pixel k ticks 1 + 2k clocks after reset release, leaves render_lat later
	always @(negedge clk_in) begin
		int k;
		if (frame_on && cyc >= frame_start && cyc < frame_start + frame_clk &&
			((cyc - 1 - render_lat) % 2 == 0)) begin
			k = ((cyc - 1 - render_lat) / 2) % (h_total * v_total);
			check_rgb(rgb, ref_colour(k % h_total, k / h_total),
				$sformatf("rgb at pixel %0d,%0d", k % h_total, k / h_total));
		end
	end

	// Sync edge timing
	always @(negedge clk_in) begin
		if (!rst) begin
			if (hs_d && !hsync) begin
				if (hs_last > 0) begin
					check_cycles(cyc - hs_last, line_clk, "hsync period");
					hs_meas++;
				end
				hs_last = cyc;
			end
			if (vs_d && !vsync) begin
				if (vs_fall > 0) begin
					check_cycles(cyc - vs_fall, frame_clk, "vsync period");
					vs_meas++;
				end
				vs_fall = cyc;
			end
			if (!vs_d && vsync && vs_fall > 0) begin
				check_cycles(cyc - vs_fall, 2 * h_total * v_pulse, "vsync low width");
				vsw_meas++;
			end
		end
		hs_d = hsync;
		vs_d = vsync;
	end

	initial begin
		rst       = 1'b1;
		cmd_valid = 1'b0;
		cmd_op    = op_up;
		mptr      = '0;
		for (int x = 0; x < grid_w; x++)
			for (int y = 0; y < grid_h; y++)
				model[x][y] = cell_hidden; // Sweep result
		repeat (4) @(posedge clk_in);
		rst <= 1'b0;
		@(negedge clk_in);
		check_pos(pointer_pos, '0, "pointer after reset");
		if (cmd_ready !== 1'b0) begin
			$display("Fail at time %0t: cmd_ready is %b right after reset, expected 0",
				$time, cmd_ready);
			report_fail();
		end
		@(posedge clk_in);
		cmd_valid <= 1'b1;
		cmd_op    <= op_down; // Held through the sweep
		stall = 0;
		@(posedge clk_in);
		while (!cmd_ready) begin
			stall++;
			@(posedge clk_in);
		end
		cmd_valid <= 1'b0;
		if (stall < cell_count - 1) begin // Sweep takes one clock per cell
			$display("Fail at time %0t: cmd_ready rose after %0d clocks, before the sweep ended",
				$time, stall);
			report_fail();
		end
		repeat (2) @(negedge clk_in); // pointer_state follows the move a clock later
		check_state(pointer_state, cell_hidden, "state under pointer after sweep");
		@(posedge clk_in);
		repeat (grid_h + 2) send_cmd(op_up);     // Past every edge
		repeat (grid_w + 2) send_cmd(op_left);
		mark_sequence();
		repeat (grid_w + 2) send_cmd(op_right);
		repeat (grid_h + 2) send_cmd(op_down);
		mark_sequence();
		for (int n = 0; n < 600; n++) begin
			take_bits(3, v);
			if (v > 5)
				v = v - 6; // Fold 6,7 onto up,down
			send_cmd(cmd_op_t'(3'(v)));
		end
		repeat (2) @(negedge clk_in);
		// Next frame start
		frame_start = ((cyc - 1 - render_lat) / frame_clk + 1) * frame_clk + 1 + render_lat;
		frame_on    = 1'b1;
		while (cyc < frame_start + frame_clk)
			@(negedge clk_in);
		if (hs_meas > 0 && vs_meas > 0 && vsw_meas > 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("No sync edge pair was measured during the run");
			report_fail();
		end
	end

endmodule

/* sim/grid_display_chk.sv */
`timescale 1ns/1ps

// Handshake and sync checks on the top level
module grid_display_chk import grid_pkg::*; (
	input logic    clk_in,
	input logic    rst,
	input logic    cmd_valid,
	input logic    cmd_ready,
	input cmd_op_t cmd_op,
	input logic    act_ready, // Engine sweep done
	input logic    hsync
);

	logic [8:0] hs_low; // Consecutive low clocks of hsync

	always_ff @(posedge clk_in) begin
		if (rst)
			hs_low <= '0;
		else if (!hsync)
			hs_low <= hs_low + 9'd1;
		else
			hs_low <= '0;
	end

	// Sender holds the op while stalled
	a_op_hold: assert property (@(posedge clk_in) disable iff (rst)
		cmd_valid && !cmd_ready |=> $stable(cmd_op))
		else $error("cmd_op changed while a command was stalled");

	a_sweep_stall: assert property (@(posedge clk_in) disable iff (rst)
		!act_ready |-> !cmd_ready)
		else $error("cmd_ready high during the reset sweep");

	// Pulse is h_pulse pixels at two clocks each
	a_hs_width: assert property (@(posedge clk_in) disable iff (rst)
		$rose(hsync) |-> (hs_low == 9'(2 * h_pulse)))
		else $error("hsync low pulse has the wrong width");

endmodule

bind grid_display_top grid_display_chk u_chk (
	.clk_in    (clk_in),
	.rst       (rst),
	.cmd_valid (cmd_valid),
	.cmd_ready (cmd_ready),
	.cmd_op    (cmd_op),
	.act_ready (act_ready),
	.hsync     (hsync)
);

/* source/grid_display_top.sv */
`timescale 1ns/1ps

// Grid display subsystem, single clock domain
module grid_display_top import grid_pkg::*; (
	input  logic        clk_in,
	input  logic        rst,
	input  logic        cmd_valid,
	output logic        cmd_ready,
	input  cmd_op_t     cmd_op,
	output rgb_t        rgb,
	output logic        hsync,
	output logic        vsync,
	output cell_pos_t   pointer_pos,
	output cell_state_t pointer_state
);

	logic        pix_tick;   // Pixel strobe, every second clock
	pixel_pos_t  pix;        // Raster position and raw syncs
	logic        act_valid;  // Cell action handshake
	logic        act_ready;
	cell_op_t    act;
	cell_pos_t   disp_addr;  // Renderer read port
	cell_state_t disp_state;

	vga_sync u_sync (
		.clk_in (clk_in),
		.rst    (rst),
		.tick   (pix_tick),
		.pix    (pix)
	);

	pointer_mover u_mover (
		.clk_in      (clk_in),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd_op      (cmd_op),
		.act_valid   (act_valid),
		.act_ready   (act_ready),
		.act         (act),
		.pointer_pos (pointer_pos)
	);

	grid_engine u_engine (
		.clk_in        (clk_in),
		.rst           (rst),
		.act_valid     (act_valid),
		.act_ready     (act_ready),
		.act           (act),
		.pointer_pos   (pointer_pos),
		.pointer_state (pointer_state),
		.disp_addr     (disp_addr),
		.disp_state    (disp_state)
	);

	pixel_renderer u_render (
		.clk_in      (clk_in),
		.rst         (rst),
		.tick        (pix_tick),
		.pix         (pix),
		.pointer_pos (pointer_pos),
		.disp_addr   (disp_addr),
		.disp_state  (disp_state),
		.rgb         (rgb),
		.hsync       (hsync),
		.vsync       (vsync)
	);

endmodule

/* source/pixel_renderer.sv */
`timescale 1ns/1ps

// Two stage colour pipe, one pixel per tick
// Stage 1 looks up the cell, stage 2 picks the colour
module pixel_renderer import grid_pkg::*; (
	input  logic        clk_in,
	input  logic        rst,
	input  logic        tick,
	input  pixel_pos_t  pix,
	input  cell_pos_t   pointer_pos,
	output cell_pos_t   disp_addr,
	input  cell_state_t disp_state,
	output rgb_t        rgb,
	output logic        hsync,
	output logic        vsync
);

	logic [9:0] cx; // Cell column, wide enough for blanking
	logic [9:0] cy;
	logic [9:0] rx; // Offset inside the cell
	logic [9:0] ry;
	logic       on_ptr;
	logic       on_edge;

	logic s1_valid;
	logic s1_active;
	logic s1_border;
	logic s1_hs;
	logic s1_vs;

	// Divide by cell size; the engine registers the read
	always_comb begin
		cx      = pix.x / 10'(cell_px);
		cy      = pix.y / 10'(cell_px);
		rx      = pix.x - cx * 10'(cell_px);
		ry      = pix.y - cy * 10'(cell_px);
		on_ptr  = (cx == 10'(pointer_pos.x)) && (cy == 10'(pointer_pos.y));
		on_edge = (rx == 10'd0) || (rx == 10'(cell_px - 1)) ||
			(ry == 10'd0) || (ry == 10'(cell_px - 1)); // First or last row/column
	end

	assign disp_addr = '{x: cx[3:0], y: cy[3:0]};

	// Stage 1, side info lined up with disp_state
	always_ff @(posedge clk_in) begin
		if (rst) begin
			s1_valid  <= 1'b0;
			s1_active <= 1'b0;
			s1_border <= 1'b0;
			s1_hs     <= 1'b1;
			s1_vs     <= 1'b1;
		end else begin
			s1_valid <= tick;
			if (tick) begin
				s1_active <= pix.active;
				s1_border <= pix.active && on_ptr && on_edge;
				s1_hs     <= pix.hsync;
				s1_vs     <= pix.vsync;
			end
		end
	end

	// Stage 2, colour select and sync out
	always_ff @(posedge clk_in) begin
		if (rst) begin
			rgb   <= col_black;
			hsync <= 1'b1; // Inactive
			vsync <= 1'b1;
		end else if (s1_valid) begin
			hsync <= s1_hs;
			vsync <= s1_vs;
			if (!s1_active)
				rgb <= col_black; // Porches and sync
			else if (s1_border)
				rgb <= col_pointer;
			else begin
				case (disp_state)
					cell_revealed: rgb <= col_revealed;
					cell_flagged:  rgb <= col_flagged;
					default:       rgb <= col_hidden;
				endcase
			end
		end
	end

endmodule

/* source/grid_engine.sv */
`timescale 1ns/1ps

// Cell state store
// One write port (sweep or action), two registered read ports
module grid_engine import grid_pkg::*; (
	input  logic        clk_in,
	input  logic        rst,
	input  logic        act_valid,
	output logic        act_ready,
	input  cell_op_t    act,
	input  cell_pos_t   pointer_pos,
	output cell_state_t pointer_state,
	input  cell_pos_t   disp_addr,
	output cell_state_t disp_state
);

	cell_state_t mem [cell_count];

	logic [cell_idx_w-1:0] sweep_idx;
	logic                  ready_q;  // Sweep finished
	logic                  act_fire;
	logic [cell_idx_w-1:0] act_idx;
	logic [cell_idx_w-1:0] ptr_idx;
	logic [cell_idx_w-1:0] disp_idx;
	logic                  disp_in;  // Display address falls inside the grid
	logic                  wr_en;
	logic [cell_idx_w-1:0] wr_idx;
	cell_state_t           wr_data;

	// Row major index, grid_w cells per row
	function automatic logic [cell_idx_w-1:0] cell_index(cell_pos_t p);
		return cell_idx_w'(p.y) * cell_idx_w'(grid_w) + cell_idx_w'(p.x);
	endfunction

	// Marking rules; revealed is final
	function automatic cell_state_t apply_op(cell_state_t cur, cmd_op_t op);
		cell_state_t nxt;
		nxt = cur;
		case (op)
			op_reveal: if (cur == cell_hidden) nxt = cell_revealed;
			op_flag: begin
				if (cur == cell_hidden)
					nxt = cell_flagged;
				else if (cur == cell_flagged)
					nxt = cell_hidden;
			end
			default: nxt = cur;
		endcase
		return nxt;
	endfunction

	assign act_ready = ready_q;
	assign act_fire  = act_valid && ready_q;
	assign act_idx   = cell_index(act.pos);
	assign ptr_idx   = cell_index(pointer_pos);
	assign disp_idx  = cell_index(disp_addr);
	assign disp_in   = disp_addr.y < 4'(grid_h); // Blanking rows land past the grid

	// Write port, sweep owns it until ready
	assign wr_en   = !ready_q || act_fire;
	assign wr_idx  = ready_q ? act_idx : sweep_idx;
	assign wr_data = ready_q ? apply_op(mem[act_idx], act.op) : cell_hidden; // Read-modify-write

	always_ff @(posedge clk_in) begin
		if (rst) begin
			sweep_idx <= '0;
			ready_q   <= 1'b0;
		end else if (!ready_q) begin
			sweep_idx <= sweep_idx + 1'b1; // One cell per clock
			if (sweep_idx == cell_idx_w'(cell_count - 1))
				ready_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_in) begin
		if (wr_en)
			mem[wr_idx] <= wr_data;
	end

	// Read ports forward a same-clock write so updates show one clock later
	always_ff @(posedge clk_in) begin
		if (rst) begin
			pointer_state <= cell_hidden;
			disp_state    <= cell_hidden;
		end else begin
			pointer_state <= (wr_en && (wr_idx == ptr_idx)) ? wr_data : mem[ptr_idx];
			if (!disp_in)
				disp_state <= cell_hidden; // Never shown, inactive area
			else if (wr_en && (wr_idx == disp_idx))
				disp_state <= wr_data;
			else
				disp_state <= mem[disp_idx];
		end
	end

endmodule

/* source/pointer_mover.sv */
`timescale 1ns/1ps

// Takes the user command stream
// Moves are absorbed here, reveal and flag go on to the grid engine
module pointer_mover import grid_pkg::*; (
	input  logic      clk_in,
	input  logic      rst,
	input  logic      cmd_valid,
	output logic      cmd_ready,
	input  cmd_op_t   cmd_op,
	output logic      act_valid,
	input  logic      act_ready,
	output cell_op_t  act,
	output cell_pos_t pointer_pos
);

	logic      is_act;   // Pending command targets a cell
	logic      online_q; // Engine has been seen ready once
	logic      move_go;  // Move transfer this clock
	cell_pos_t pos_next;

	assign is_act = (cmd_op == op_reveal) || (cmd_op == op_flag);

	// Actions wait on the engine; moves only wait for the sweep to be over
	assign cmd_ready = is_act ? act_ready : online_q;
	assign act_valid = cmd_valid && is_act;
	assign act       = '{pos: pointer_pos, op: cmd_op}; // Position at transfer time
	assign move_go   = cmd_valid && cmd_ready && !is_act;

	// Clamped step, edges hold the pointer in place
	always_comb begin
		pos_next = pointer_pos;
		case (cmd_op)
			op_up:    if (pointer_pos.y != 4'd0) pos_next.y = pointer_pos.y - 4'd1;
			op_down:  if (pointer_pos.y != 4'(grid_h - 1)) pos_next.y = pointer_pos.y + 4'd1;
			op_left:  if (pointer_pos.x != 4'd0) pos_next.x = pointer_pos.x - 4'd1;
			op_right: if (pointer_pos.x != 4'(grid_w - 1)) pos_next.x = pointer_pos.x + 4'd1;
			default:  pos_next = pointer_pos; // Actions leave the pointer alone
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (rst) begin
			pointer_pos <= '0; // Top left cell
			online_q    <= 1'b0;
		end else begin
			if (act_ready)
				online_q <= 1'b1; // Sticky, engine never drops ready again
			if (move_go)
				pointer_pos <= pos_next;
		end
	end

endmodule

/* source/vga_sync.sv */
`timescale 1ns/1ps

// Pixel tick and raster counters for 640x480
// The tick is high on every second clock; pix is valid while tick is high
module vga_sync import grid_pkg::*; (
	input  logic       clk_in,
	input  logic       rst,
	output logic       tick,
	output pixel_pos_t pix
);

	logic [9:0] h_cnt; // Current pixel column
	logic [9:0] v_cnt; // Current line
	logic [9:0] h_next;
	logic [9:0] v_next;
	logic       line_end;
	logic       act_next;
	logic       hs_next;
	logic       vs_next;
	logic       act_q;
	logic       hs_q;
	logic       vs_q;

	// Next raster position, taken on the edge that closes a tick cycle
	always_comb begin
		line_end = (h_cnt == 10'(h_total - 1));
		h_next   = line_end ? 10'd0 : h_cnt + 10'd1;
		if (!line_end)
			v_next = v_cnt;
		else if (v_cnt == 10'(v_total - 1))
			v_next = 10'd0; // Frame wrap
		else
			v_next = v_cnt + 10'd1;
	end

	// Flags for the next position, so they land together with the counters
	always_comb begin
		act_next = (h_next < 10'(h_active)) && (v_next < 10'(v_active));
		hs_next  = !((h_next >= 10'(h_active + h_front)) &&
			(h_next < 10'(h_active + h_front + h_pulse)));  // Low in the h pulse
		vs_next  = !((v_next >= 10'(v_active + v_front)) &&
			(v_next < 10'(v_active + v_front + v_pulse)));  // Low in the v pulse
	end

	always_ff @(posedge clk_in) begin
		if (rst) begin
			tick  <= 1'b0;
			h_cnt <= '0;
			v_cnt <= '0;
			act_q <= 1'b1; // Pixel 0,0 is visible
			hs_q  <= 1'b1;
			vs_q  <= 1'b1;
		end else begin
			tick <= ~tick; // Half rate pixel clock
			if (tick) begin
				h_cnt <= h_next;
				v_cnt <= v_next;
				act_q <= act_next;
				hs_q  <= hs_next;
				vs_q  <= vs_next;
			end
		end
	end

	assign pix = '{x: h_cnt, y: v_cnt, active: act_q, hsync: hs_q, vsync: vs_q};

endmodule

/* source/grid_pkg.sv */
package grid_pkg;

	// VGA 640x480 timing, in pixels for h and lines for v
	localparam int h_active = 640;
	localparam int h_front  = 16;
	localparam int h_pulse  = 96;
	localparam int h_back   = 48;
	localparam int h_total  = 800; // Sum of the four above

	localparam int v_active = 480;
	localparam int v_front  = 10;
	localparam int v_pulse  = 2;
	localparam int v_back   = 33;
	localparam int v_total  = 525;

	// Grid geometry
	localparam int cell_px    = 40;                  // Cell edge in pixels
	localparam int grid_w     = 16;                  // Cells per row
	localparam int grid_h     = 12;                  // Cells per column
	localparam int cell_count = 192;                 // grid_w * grid_h
	localparam int cell_idx_w = $clog2(cell_count);  // Linear cell index width

	// Clocks from pixel tick to rgb/hsync/vsync out of the renderer
	localparam int render_lat = 2;

	typedef enum logic [1:0] {
		cell_hidden   = 2'd0,
		cell_revealed = 2'd1,
		cell_flagged  = 2'd2
	} cell_state_t;

	typedef enum logic [2:0] {
		op_up     = 3'd0,
		op_down   = 3'd1,
		op_left   = 3'd2,
		op_right  = 3'd3,
		op_reveal = 3'd4,
		op_flag   = 3'd5
	} cmd_op_t;

	typedef struct packed {
		logic [3:0] x; // Column, 0..grid_w-1
		logic [3:0] y; // Row, 0..grid_h-1
	} cell_pos_t;

	// One pixel as it leaves the sync generator
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       active; // Inside the visible area
		logic       hsync;  // Raw, active low
		logic       vsync;  // Raw, active low
	} pixel_pos_t;

	typedef struct packed {
		cell_pos_t pos;
		cmd_op_t   op; // Only reveal or flag travel this way
	} cell_op_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	// Palette
	localparam rgb_t col_black    = 12'h000;
	localparam rgb_t col_hidden   = 12'h888;
	localparam rgb_t col_revealed = 12'hFFF;
	localparam rgb_t col_flagged  = 12'hF00;
	localparam rgb_t col_pointer  = 12'hFF0;

endpackage
